/* trace_mon_pkg.sv */
// Trace monitor types: width constants, trace and decode structs, nop and message enums
`default_nettype none

package trace_mon_pkg;

   localparam int DATA_W    = 32;  // pc, insn, writeback and r3 width
   localparam int REG_IDX_W = 5;   // OR1K GPR index
   localparam int CORE_ID_W = 4;   // Core tag, so at most 16 cores
   localparam int PUTC_W    = 8;   // Character bits kept for putc

   // Simulation nop encoding l.nop K
   localparam logic [15:0] NOP_OPC = 16'h1500;
   localparam logic [15:0] NOP_K_EXIT   = 16'h0001;
   localparam logic [15:0] NOP_K_REPORT = 16'h0002;
   localparam logic [15:0] NOP_K_PUTC   = 16'h0004;

   localparam logic [REG_IDX_W-1:0] REG_R3 = 5'd3;  // Return value / argument register

   // Raw execution trace entry, 103 bits, enable at the MSB
   typedef struct packed {
      logic                 enable;
      logic [DATA_W-1:0]    pc;
      logic [DATA_W-1:0]    insn;
      logic                 wben;
      logic [REG_IDX_W-1:0] wbreg;
      logic [DATA_W-1:0]    wbdata;
   } trace_exec_t;

   typedef enum logic [1:0] {
      NOP_NONE,
      NOP_EXIT,
      NOP_REPORT,
      NOP_PUTC
   } nop_kind_e;

   // Stage 1 output
   typedef struct packed {
      logic              valid;
      nop_kind_e         nop_kind;
      logic              r3_we;   // Writeback hits r3
      logic [DATA_W-1:0] wbdata;
   } trace_dec_t;

   typedef enum logic {
      MSG_REPORT,
      MSG_PUTC
   } msg_kind_e;

   typedef struct packed {
      msg_kind_e         kind;
      logic [DATA_W-1:0] data;  // Full r3 or masked char
   } msg_t;

   // Message tagged with its source core
   typedef struct packed {
      logic [CORE_ID_W-1:0] core;
      msg_t                 msg;
   } core_msg_t;

endpackage

`default_nettype wire

/* trace_unpack.sv */
// Per-core stage 1: trace entry register with nop classification and r3 write detect
`default_nettype none
`timescale 1ns/10ps

module trace_unpack (
   input  logic                       clk,
   input  logic                       arst_n,
   input  trace_mon_pkg::trace_exec_t entry,
   output trace_mon_pkg::trace_dec_t  dec
);

   import trace_mon_pkg::*;

   nop_kind_e  nop_kind;  // Kind of the incoming insn
   trace_dec_t dec_d;

   // l.nop K: upper half fixed, K picks the kind
   always_comb begin
      nop_kind = NOP_NONE;
      if (entry.insn[31:16] == NOP_OPC) begin
         case (entry.insn[15:0])
            NOP_K_EXIT:   nop_kind = NOP_EXIT;
            NOP_K_REPORT: nop_kind = NOP_REPORT;
            NOP_K_PUTC:   nop_kind = NOP_PUTC;
            default:      nop_kind = NOP_NONE;  // Other K values are plain nops
         endcase
      end
   end

   // Disabled slot decodes to all zero
   always_comb begin
      dec_d = '0;
      if (entry.enable) begin
         dec_d.valid    = 1'b1;
         dec_d.nop_kind = nop_kind;
         dec_d.r3_we    = entry.wben && (entry.wbreg == REG_R3);
         dec_d.wbdata   = entry.wbdata;  // Only used when r3_we
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec <= '0;
      end else begin
         dec <= dec_d;  // One cycle after the entry
      end
   end

endmodule

`default_nettype wire

/* event_classify.sv */
// Per-core stage 2: r3 shadow register, exit pulse and report/putc message generation
`default_nettype none
`timescale 1ns/10ps

module event_classify (
   input  logic                      clk,
   input  logic                      arst_n,
   input  trace_mon_pkg::trace_dec_t dec,
   output logic                      exit_valid,
   output logic [31:0]               exit_code,
   output logic                      msg_valid,
   output trace_mon_pkg::msg_t       msg
);

   import trace_mon_pkg::*;

   logic [DATA_W-1:0] r3_q;     // Shadow of r3, holds all earlier writes
   logic              is_exit;
   logic              is_msg;
   msg_t              msg_d;

   assign is_exit = dec.valid && (dec.nop_kind == NOP_EXIT);
   assign is_msg  = dec.valid &&
                    ((dec.nop_kind == NOP_REPORT) || (dec.nop_kind == NOP_PUTC));

   // Shadow update
   // Events below sample r3_q, i.e. the value before this entry
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         r3_q <= '0;
      end else if (dec.valid && dec.r3_we) begin
         r3_q <= dec.wbdata;
      end
   end

   // Message payload from the shadow
   always_comb begin
      msg_d.kind = MSG_REPORT;
      msg_d.data = r3_q;  // Report carries all of r3
      if (dec.nop_kind == NOP_PUTC) begin
         msg_d.kind = MSG_PUTC;
         msg_d.data = {{(DATA_W-PUTC_W){1'b0}}, r3_q[PUTC_W-1:0]};  // Char only
      end
   end

   // Strobes, two cycles after the trace entry
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exit_valid <= 1'b0;
         msg_valid  <= 1'b0;
      end else begin
         exit_valid <= is_exit;
         msg_valid  <= is_msg;
      end
   end

   // Payload beside the strobes
   always_ff @(posedge clk) begin
      if (is_exit) begin
         exit_code <= r3_q;  // Exit code is r3
      end
      if (is_msg) begin
         msg <= msg_d;
      end
   end

endmodule

`default_nettype wire

/* msg_arbiter.sv */
// Per-core message FIFOs, round-robin drain to one core-tagged stream, sticky overflow flags
`default_nettype none
`timescale 1ns/10ps

module msg_arbiter #(
   parameter int NUM_CORES   = 4,
   parameter int QUEUE_DEPTH = 4  // Power of two, at least 2
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [NUM_CORES-1:0]                 in_valid,
   input  trace_mon_pkg::msg_t [NUM_CORES-1:0]  in_msg,
   output logic                                 out_valid,
   output trace_mon_pkg::core_msg_t             out_msg,
   output logic [NUM_CORES-1:0]                 overflow
);

   import trace_mon_pkg::*;

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(QUEUE_DEPTH);

   msg_t                 mem    [NUM_CORES][QUEUE_DEPTH];  // Queue storage
   logic [PTR_W-1:0]     rd_ptr [NUM_CORES];
   logic [PTR_W-1:0]     wr_ptr [NUM_CORES];
   logic [PTR_W:0]       count  [NUM_CORES];  // Entries held
   logic [NUM_CORES-1:0] pop;        // One-hot grant
   logic [NUM_CORES-1:0] push;
   logic [CORE_ID_W-1:0] last_grant; // RR pointer
   logic [CORE_ID_W-1:0] grant_idx;
   msg_t                 head;       // Popped entry

   // Round-robin pick, starting after the last grant
   always_comb begin
      int   idx;
      logic found;
      idx       = 0;
      found     = 1'b0;
      pop       = '0;
      grant_idx = last_grant;
      head      = '0;
      for (int k = 1; k <= NUM_CORES; k++) begin
         idx = (int'(last_grant) + k) % NUM_CORES;
         if (!found && (count[idx] != '0)) begin
            found     = 1'b1;
            pop[idx]  = 1'b1;
            grant_idx = CORE_ID_W'(idx);
            head      = mem[idx][rd_ptr[idx]];
         end
      end
   end

   // Full queue still takes one if it is popped now
   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         push[c] = in_valid[c] && ((count[c] != FULL_CNT) || pop[c]);
      end
   end

   assign out_valid = |pop;  // Same cycle as the pop
   assign out_msg   = '{core: grant_idx, msg: head};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            rd_ptr[c] <= '0;
            wr_ptr[c] <= '0;
            count[c]  <= '0;
         end
         overflow   <= '0;
         last_grant <= CORE_ID_W'(NUM_CORES-1);  // Core 0 goes first
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (push[c]) wr_ptr[c] <= wr_ptr[c] + 1'b1;  // Wraps, depth is 2^n
            if (pop[c])  rd_ptr[c] <= rd_ptr[c] + 1'b1;
            case ({push[c], pop[c]})
               2'b10:   count[c] <= count[c] + 1'b1;
               2'b01:   count[c] <= count[c] - 1'b1;
               default: count[c] <= count[c];  // Idle or push+pop
            endcase
            if (in_valid[c] && !push[c]) begin
               overflow[c] <= 1'b1;  // Dropped, sticky until reset
            end
         end
         if (|pop) last_grant <= grant_idx;
      end
   end

   // Storage write
   always_ff @(posedge clk) begin
      for (int c = 0; c < NUM_CORES; c++) begin
         if (push[c]) mem[c][wr_ptr[c]] <= in_msg[c];
      end
   end

endmodule

`default_nettype wire

/* term_collect.sv */
// Termination collector: first exit code per core, termination mask and all-done level
`default_nettype none
`timescale 1ns/10ps

module term_collect #(
   parameter int NUM_CORES = 4
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [NUM_CORES-1:0]        exit_valid,
   input  logic [NUM_CORES-1:0][31:0]  exit_code,
   output logic [NUM_CORES-1:0]        term_mask,
   output logic [NUM_CORES-1:0][31:0]  exit_codes,
   output logic                        all_done
);

   logic [NUM_CORES-1:0] first_exit;  // Exit from a core not yet terminated

   assign first_exit = exit_valid & ~term_mask;

   // Later exits of a core leave its code alone
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         term_mask  <= '0;
         exit_codes <= '0;
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (first_exit[c]) begin
               term_mask[c]  <= 1'b1;
               exit_codes[c] <= exit_code[c];
            end
         end
      end
   end

   // One cycle behind the last mask bit
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         all_done <= 1'b0;
      end else begin
         all_done <= &term_mask;
      end
   end

endmodule

`default_nettype wire

/* trace_monitor_top.sv */
// Trace monitor top: per-core unpack and classify stages, message arbiter and termination collector
`default_nettype none
`timescale 1ns/10ps

module trace_monitor_top #(
   parameter int NUM_CORES   = 4,  // Up to 16, core tag is 4 bits
   parameter int QUEUE_DEPTH = 4   // Per-core message queue, power of two
) (
   input  logic                                      clk,
   input  logic                                      arst_n,
   input  trace_mon_pkg::trace_exec_t [NUM_CORES-1:0] trace,
   output logic                                      out_valid,
   output trace_mon_pkg::core_msg_t                  out_msg,
   output logic [NUM_CORES-1:0]                      overflow,
   output logic [NUM_CORES-1:0]                      term_mask,
   output logic [NUM_CORES-1:0][31:0]                exit_codes,
   output logic                                      all_done
);

   import trace_mon_pkg::*;

   trace_dec_t [NUM_CORES-1:0]        dec;         // Stage 1 to stage 2
   logic [NUM_CORES-1:0]              exit_valid;
   logic [NUM_CORES-1:0][31:0]        exit_code;
   logic [NUM_CORES-1:0]              msg_valid;
   msg_t [NUM_CORES-1:0]              msg;

   genvar i;

   generate
      for (i = 0; i < NUM_CORES; i++) begin : g_core
         // Decode, one cycle
         trace_unpack u_unpack (
            .clk    (clk),
            .arst_n (arst_n),
            .entry  (trace[i]),
            .dec    (dec[i])
         );

         // r3 tracking and events, second cycle
         event_classify u_classify (
            .clk        (clk),
            .arst_n     (arst_n),
            .dec        (dec[i]),
            .exit_valid (exit_valid[i]),
            .exit_code  (exit_code[i]),
            .msg_valid  (msg_valid[i]),
            .msg        (msg[i])
         );
      end
   endgenerate

   // Shared message path
   msg_arbiter #(
      .NUM_CORES   (NUM_CORES),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_arbiter (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (msg_valid),
      .in_msg    (msg),
      .out_valid (out_valid),
      .out_msg   (out_msg),
      .overflow  (overflow)
   );

   // Shared termination tracking
   term_collect #(
      .NUM_CORES (NUM_CORES)
   ) u_term (
      .clk        (clk),
      .arst_n     (arst_n),
      .exit_valid (exit_valid),
      .exit_code  (exit_code),
      .term_mask  (term_mask),
      .exit_codes (exit_codes),
      .all_done   (all_done)
   );

endmodule

`default_nettype wire

/* tb_trace_monitor.sv */
// Testbench for trace_monitor_top: LCG stimulus, r3/message/exit model, compare tasks, watchdog
`default_nettype none
`timescale 1ns/10ps

module tb_trace_monitor;

   import trace_mon_pkg::*;

   localparam int NUM_CORES    = 4;
   localparam int QUEUE_DEPTH  = 4;
   localparam int RESET_CYCLES = 5;
   localparam int RAND_CYCLES  = 400;
   localparam int TERM_CYCLES  = 60;   // Exit sequences with their waits
   localparam int BURST_CYCLES = 40;   // Putc burst plus drain
   localparam int STIM_CYCLES  = RESET_CYCLES + RAND_CYCLES + TERM_CYCLES + BURST_CYCLES;
   localparam int QUIET_LIMIT  = 64;   // Cycles allowed for the queues to empty

   // l.nop K values
   localparam logic [15:0] K_EXIT   = 16'h0001;
   localparam logic [15:0] K_REPORT = 16'h0002;
   localparam logic [15:0] K_PUTC   = 16'h0004;

   logic                        clk;
   logic                        arst_n;
   trace_exec_t [NUM_CORES-1:0] trace;
   logic                        out_valid;
   core_msg_t                   out_msg;
   logic [NUM_CORES-1:0]        overflow;
   logic [NUM_CORES-1:0]        term_mask;
   logic [NUM_CORES-1:0][31:0]  exit_codes;
   logic                        all_done;

   logic [31:0]          seed;
   logic [31:0]          shadow   [NUM_CORES];  // Model r3 per core
   msg_t                 exp_q    [NUM_CORES][$];
   logic [NUM_CORES-1:0] exp_term;
   logic [31:0]          exp_code [NUM_CORES];
   int                   gap      [NUM_CORES];  // Cycles since last nop
   logic                 allow_drops;           // Burst phase

   trace_monitor_top #(
      .NUM_CORES   (NUM_CORES),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .trace      (trace),
      .out_valid  (out_valid),
      .out_msg    (out_msg),
      .overflow   (overflow),
      .term_mask  (term_mask),
      .exit_codes (exit_codes),
      .all_done   (all_done)
   );

   always #4 clk = ~clk;  // 8 ns period

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "Run stopped at first error");
   endtask

   initial begin
      #(20 * STIM_CYCLES * 8);
      abort_run("Watchdog timeout, the tests did not finish in time");
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [31:0] plain_insn();
      logic [31:0] insn;
      insn = lcg_next();
      if (insn[31:16] == NOP_OPC) insn[31] = 1'b1;  // Stay clear of sim nops
      return insn;
   endfunction

   function automatic trace_exec_t make_entry(input logic en, input logic [31:0] insn,
                                              input logic wben, input logic [4:0] wbreg,
                                              input logic [31:0] wbdata);
      trace_exec_t e;
      e.enable = en;
      e.pc     = lcg_next() & 32'hFFFF_FFFC;
      e.insn   = insn;
      e.wben   = wben;
      e.wbreg  = wbreg;
      e.wbdata = wbdata;
      return e;
   endfunction

   // Reference rules: events see r3 from earlier entries only
   task automatic apply_model(input int c, input trace_exec_t e);
      msg_t m;
      if (e.enable) begin
         if (e.insn[31:16] == NOP_OPC) begin
            if (e.insn[15:0] == K_EXIT && !exp_term[c]) begin
               exp_term[c] = 1'b1;  // First exit only
               exp_code[c] = shadow[c];
            end else if (e.insn[15:0] == K_REPORT) begin
               m.kind = MSG_REPORT;
               m.data = shadow[c];
               exp_q[c].push_back(m);
            end else if (e.insn[15:0] == K_PUTC) begin
               m.kind = MSG_PUTC;
               m.data = {24'h0, shadow[c][7:0]};  // Char byte only
               exp_q[c].push_back(m);
            end
         end
         if (e.wben && e.wbreg == 5'd3) shadow[c] = e.wbdata;
      end
   endtask

   task automatic send(input int c, input trace_exec_t e);
      apply_model(c, e);
      trace[c] <= e;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      trace <= '0;
   endtask

   task automatic check_msg(input core_msg_t got, input core_msg_t exp);
      if (got !== exp) abort_run($sformatf("FAIL out_msg: got %h expected %h", got, exp));
   endtask

   task automatic check_exit(input int core, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("FAIL exit_codes[%0d]: got %h expected %h", core, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic [NUM_CORES-1:0] got,
                             input logic [NUM_CORES-1:0] exp);
      if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
   endtask

   // One random entry, nops at least four cycles apart per core
   task automatic drive_random(input int c);
      logic [31:0] r;
      logic [4:0]  reg_idx;
      trace_exec_t e;
      r       = lcg_next();
      reg_idx = r[27:23];
      if (reg_idx == 5'd3) reg_idx = 5'd4;
      gap[c]++;
      case (r[30:28])
         3'd0:       e = make_entry(1'b0, r[26] ? {NOP_OPC, K_PUTC} : plain_insn(),
                                    1'b1, 5'd3, lcg_next());  // Disabled junk
         3'd1, 3'd2: e = make_entry(1'b1, plain_insn(), 1'b1, 5'd3, lcg_next());
         3'd3:       e = make_entry(1'b1, plain_insn(), 1'b1, reg_idx, lcg_next());
         3'd4:       e = make_entry(1'b1, r[26] ? {NOP_OPC, 16'h0000} : plain_insn(),
                                    1'b0, 5'd0, 32'd0);
         default: begin
            if (gap[c] >= 4) begin
               gap[c] = 0;
               e = make_entry(1'b1, {NOP_OPC, r[27] ? K_REPORT : K_PUTC}, 1'b0, 5'd0, 32'd0);
            end else begin
               e = make_entry(1'b1, plain_insn(), 1'b0, 5'd0, 32'd0);
            end
         end
      endcase
      send(c, e);
   endtask

   // Pipeline flush, then wait for empty queues
   task automatic wait_quiet();
      int n;
      n = 0;
      idle_cycle();
      repeat (3) @(posedge clk);
      @(negedge clk);
      while (out_valid && n < QUIET_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (out_valid) abort_run("Message stream did not drain in time");
   endtask

   task automatic wait_term(input int c);
      int n;
      n = 0;
      @(negedge clk);
      while (!term_mask[c] && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (!term_mask[c]) abort_run($sformatf("Exit of core %0d never reached term_mask", c));
      check_flag("term_mask", term_mask, exp_term);
      check_exit(c, exit_codes[c], exp_code[c]);
      check_flag("all_done", NUM_CORES'(all_done), '0);  // Lags the mask by one cycle
      if (c == NUM_CORES - 1) begin
         @(negedge clk);
         check_flag("all_done", NUM_CORES'(all_done), NUM_CORES'(1'b1));
      end
   endtask

   task automatic run_exits();
      logic [31:0] code;
      for (int c = 0; c < NUM_CORES; c++) begin
         code = lcg_next();
         @(posedge clk);
         send(c, make_entry(1'b1, plain_insn(), 1'b1, 5'd3, code));  // Code into r3
         @(posedge clk);
         send(c, make_entry(1'b1, {NOP_OPC, K_EXIT}, 1'b0, 5'd0, 32'd0));
         idle_cycle();
         wait_term(c);
      end
      // Late exits on cores 1 and 3 with new r3
      @(posedge clk);
      send(1, make_entry(1'b1, plain_insn(), 1'b1, 5'd3, ~exp_code[1]));
      send(3, make_entry(1'b1, plain_insn(), 1'b1, 5'd3, ~exp_code[3]));
      @(posedge clk);
      send(1, make_entry(1'b1, {NOP_OPC, K_EXIT}, 1'b0, 5'd0, 32'd0));
      send(3, make_entry(1'b1, {NOP_OPC, K_EXIT}, 1'b0, 5'd0, 32'd0));
      idle_cycle();
      repeat (6) @(negedge clk);
      check_flag("term_mask", term_mask, exp_term);
      for (int c = 0; c < NUM_CORES; c++) check_exit(c, exit_codes[c], exp_code[c]);
      check_flag("all_done", NUM_CORES'(all_done), NUM_CORES'(1'b1));
   endtask

   task automatic run_burst();
      logic [31:0] r;
      allow_drops = 1'b1;
      @(posedge clk);
      for (int c = 0; c < NUM_CORES; c++) begin
         r = lcg_next();
         send(c, make_entry(1'b1, plain_insn(), 1'b1, 5'd3, {r[31:8], 8'(65 + c)}));
      end
      repeat (16) begin
         @(posedge clk);
         for (int c = 0; c < NUM_CORES; c++) begin
            send(c, make_entry(1'b1, {NOP_OPC, K_PUTC}, 1'b0, 5'd0, 32'd0));
         end
      end
      wait_quiet();
      if (overflow == '0) abort_run("Putc burst on all cores set no overflow bit");
   endtask

   // Output checker, mid-cycle when out_msg is settled
   always @(negedge clk) begin : out_monitor
      int        c;
      int        hit;
      core_msg_t exp;
      if (arst_n && out_valid) begin
         c = int'(out_msg.core);
         if (c >= NUM_CORES) begin
            abort_run($sformatf("out_msg tagged with core %0d, which does not exist", c));
         end else if (exp_q[c].size() == 0) begin
            abort_run($sformatf("out_valid pulsed for core %0d with no message pending", c));
         end else begin
            hit = 0;
            if (allow_drops) begin
               for (int k = exp_q[c].size() - 1; k >= 0; k--) begin
                  if (exp_q[c][k] == out_msg.msg) hit = k;  // Earliest match wins
               end
            end
            for (int k = 0; k < hit; k++) exp_q[c].delete(0);  // Dropped ones
            exp.core = out_msg.core;
            exp.msg  = exp_q[c].pop_front();
            check_msg(out_msg, exp);
         end
      end
   end

   initial begin
      clk         = 1'b0;
      arst_n      = 1'b0;
      trace       = '0;
      seed        = 32'd65972;
      allow_drops = 1'b0;
      exp_term    = '0;
      for (int c = 0; c < NUM_CORES; c++) begin
         shadow[c]   = '0;
         exp_code[c] = '0;
         gap[c]      = 4;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_flag("out_valid", NUM_CORES'(out_valid), '0);
      check_flag("all_done", NUM_CORES'(all_done), '0);
      check_flag("term_mask", term_mask, '0);
      check_flag("overflow", overflow, '0);
      repeat (RAND_CYCLES) begin
         @(posedge clk);
         for (int c = 0; c < NUM_CORES; c++) drive_random(c);
      end
      wait_quiet();
      for (int c = 0; c < NUM_CORES; c++) begin
         if (exp_q[c].size() != 0) begin
            abort_run($sformatf("Core %0d has %0d messages that never came out",
                                c, exp_q[c].size()));
         end
      end
      check_flag("overflow", overflow, '0);
      check_flag("term_mask", term_mask, '0);
      check_flag("all_done", NUM_CORES'(all_done), '0);
      run_exits();
      run_burst();
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
trace_mon_pkg.sv
trace_unpack.sv
event_classify.sv
msg_arbiter.sv
term_collect.sv
trace_monitor_top.sv
tb_trace_monitor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the trace monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_trace_monitor \
   -f project.f -o sim_tb \
   && ./obj_dir/sim_tb 2>&1 | tee sim.log

grep -q "Simulation passed" sim.log 2>/dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
